/* logic/issue_pkg.sv */
// ----------------------------------------------------------------------
// issue stage package
// widths, vector types and functional unit codes shared by the
// issue and operand-read stage
// ----------------------------------------------------------------------
`default_nettype none

package issue_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS       = 2 ** REG_ADDR_BITS;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned FU_OP_BITS    = 6;

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    // integer data word
    typedef logic [XLEN-1:0]          xlen_t;
    // architectural register index
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    // scoreboard tag, travels with the instruction
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    // operation code, not decoded here
    typedef logic [FU_OP_BITS-1:0]    fu_op_t;

    // functional unit select, NONE also marks a free register in the
    // scoreboard clobber list
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ALU       = 3'd1,
        CTRL_FLOW = 3'd2,
        MULT      = 3'd3,
        LOAD      = 3'd4,
        STORE     = 3'd5,
        CSR       = 3'd6
    } fu_t;

endpackage

`default_nettype wire

/* logic/int_regfile.sv */
// ----------------------------------------------------------------------
// integer register file
// two combinational read ports, one write port per commit port,
// x0 is hardwired to zero
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module int_regfile import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                            clk_i,
    input  wire logic                            rst_ni,
    // read ports
    input  wire reg_addr_t                       raddr_a_i,
    input  wire reg_addr_t                       raddr_b_i,
    output      xlen_t                           rdata_a_o,
    output      xlen_t                           rdata_b_o,
    // commit ports
    input  wire reg_addr_t [NR_COMMIT_PORTS-1:0] waddr_i,
    input  wire xlen_t     [NR_COMMIT_PORTS-1:0] wdata_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0] we_i
);

    xlen_t regs_q [NR_REGS];

    // write on the rising edge
    // ports are scanned upwards so the highest port wins on a collision
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '{default: '0};
        end else begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                // writes to x0 are dropped
                if (we_i[p] && (waddr_i[p] != '0)) begin
                    regs_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // combinational read, a commit in this cycle shows up next cycle
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

    // x0 must stay zero whatever the commit stage sends
    x0_zero_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) regs_q[0] == '0
    ) else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

/* logic/operand_hazard.sv */
// ----------------------------------------------------------------------
// source operand hazard check
// looks rs1 and rs2 up in the clobber list, decides between
// forwarding from the scoreboard and stalling the issue
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module operand_hazard import issue_pkg::*; (
    input  wire reg_addr_t         rs1_i,
    input  wire reg_addr_t         rs2_i,
    // rs1 field holds an immediate, not a register
    input  wire logic              use_zimm_i,
    // pending producer per register, NONE when free
    input  wire fu_t [NR_REGS-1:0] rd_clobber_i,
    // scoreboard result availability
    input  wire logic              fwd_rs1_valid_i,
    input  wire logic              fwd_rs2_valid_i,
    output      logic              forward_rs1_o,
    output      logic              forward_rs2_o,
    output      logic              stall_o
);

    // result is {forward, stall}
    // a CSR result only reaches the register file, it is never forwarded
    function automatic logic [1:0] check_source(input fu_t producer, input logic fwd_valid);
        logic [1:0] result;
        if (producer == NONE) begin
            result = 2'b00;
        end else if (fwd_valid && (producer != CSR)) begin
            result = 2'b10;
        end else begin
            result = 2'b01;
        end
        return result;
    endfunction

    logic [1:0] rs1_check;
    logic [1:0] rs2_check;

    always_comb begin
        // zimm uses the rs1 field as data, no dependency there
        if (use_zimm_i) begin
            rs1_check = 2'b00;
        end else begin
            rs1_check = check_source(rd_clobber_i[rs1_i], fwd_rs1_valid_i);
        end
        rs2_check = check_source(rd_clobber_i[rs2_i], fwd_rs2_valid_i);
    end

    assign forward_rs1_o = rs1_check[1];
    assign forward_rs2_o = rs2_check[1];
    // either source missing holds the instruction back
    assign stall_o       = rs1_check[0] | rs2_check[0];

endmodule

`default_nettype wire

/* logic/id_ex_operands.sv */
// ----------------------------------------------------------------------
// operand select and ID/EX register
// picks operand a and b from register file, scoreboard, pc, zimm
// or immediate and registers the bundle for the execute stage
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module id_ex_operands import issue_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    // register file read data
    input  wire xlen_t     regfile_a_i,
    input  wire xlen_t     regfile_b_i,
    // scoreboard data and forward decision
    input  wire xlen_t     fwd_rs1_data_i,
    input  wire xlen_t     fwd_rs2_data_i,
    input  wire logic      forward_rs1_i,
    input  wire logic      forward_rs2_i,
    // instruction fields
    input  wire reg_addr_t rs1_i,
    input  wire xlen_t     pc_i,
    input  wire xlen_t     imm_i,
    input  wire logic      use_pc_i,
    input  wire logic      use_zimm_i,
    input  wire logic      use_imm_i,
    input  wire fu_t       fu_i,
    input  wire fu_op_t    op_i,
    input  wire trans_id_t trans_id_i,
    // towards execute
    output      xlen_t     operand_a_o,
    output      xlen_t     operand_b_o,
    output      xlen_t     imm_o,
    output      fu_t       fu_o,
    output      fu_op_t    op_o,
    output      trans_id_t trans_id_o
);

    xlen_t operand_a_d;
    xlen_t operand_b_d;

    // ------------------------------------------------------------------
    // operand multiplexer
    // ------------------------------------------------------------------
    always_comb begin
        // operand a, zimm over pc over forward over register file
        if (use_zimm_i) begin
            operand_a_d = {{(XLEN-REG_ADDR_BITS){1'b0}}, rs1_i};
        end else if (use_pc_i) begin
            operand_a_d = pc_i;
        end else if (forward_rs1_i) begin
            operand_a_d = fwd_rs1_data_i;
        end else begin
            operand_a_d = regfile_a_i;
        end
        // store and branch need rs2 on b, their immediate goes out on imm_o
        if (use_imm_i && (fu_i != STORE) && (fu_i != CTRL_FLOW)) begin
            operand_b_d = imm_i;
        end else if (forward_rs2_i) begin
            operand_b_d = fwd_rs2_data_i;
        end else begin
            operand_b_d = regfile_b_i;
        end
    end

    // ------------------------------------------------------------------
    // ID/EX register, loads every cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            operand_a_o <= '0;
            operand_b_o <= '0;
            imm_o       <= '0;
            fu_o        <= NONE;
            op_o        <= '0;
            trans_id_o  <= '0;
        end else begin
            operand_a_o <= operand_a_d;
            operand_b_o <= operand_b_d;
            imm_o       <= imm_i;
            fu_o        <= fu_i;
            op_o        <= op_i;
            trans_id_o  <= trans_id_i;
        end
    end

    // the execute units may sample operands in any cycle after reset
    operands_known_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !$isunknown({operand_a_o, operand_b_o})
    ) else $error("unknown bits on the ID/EX operands");

endmodule

`default_nettype wire

/* logic/issue_control.sv */
// ----------------------------------------------------------------------
// issue control
// unit busy select, WAW check, issue acknowledge and the per-unit
// valid pulses towards execute
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module issue_control import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                            clk_i,
    input  wire logic                            rst_ni,
    input  wire logic                            flush_i,
    // instruction from rename
    input  wire logic                            instr_valid_i,
    input  wire fu_t                             fu_i,
    input  wire reg_addr_t                       rd_i,
    input  wire logic                            ex_valid_i,
    // source operands not ready
    input  wire logic                            stall_i,
    input  wire fu_t       [NR_REGS-1:0]         rd_clobber_i,
    // commit ports, only the address side matters here
    input  wire reg_addr_t [NR_COMMIT_PORTS-1:0] waddr_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0] we_i,
    // unit back-pressure
    input  wire logic                            flu_ready_i,
    input  wire logic                            lsu_ready_i,
    output      logic                            issue_ack_o,
    // one pulse per unit
    output      logic                            alu_valid_o,
    output      logic                            branch_valid_o,
    output      logic                            mult_valid_o,
    output      logic                            lsu_valid_o,
    output      logic                            csr_valid_o
);

    logic fu_busy;
    logic rd_committing;
    logic issue;

    // fixed latency units share flu_ready_i, loads and stores the lsu
    always_comb begin
        unique case (fu_i)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // rd gets written by a commit port in this very cycle
    always_comb begin
        rd_committing = 1'b0;
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] == rd_i)) begin
                rd_committing = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // acknowledge
    // ------------------------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (instr_valid_i) begin
            // WAW check, rd free or freed by the commit stage now
            if (!stall_i && !fu_busy && ((rd_clobber_i[rd_i] == NONE) || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and no-unit instructions pass straight through
            if (ex_valid_i || (fu_i == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply holds the fixed latency writeback, only MULT may follow
        if (mult_valid_o && (fu_i != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // accepted and bound for a unit
    assign issue = instr_valid_i & issue_ack_o & ~ex_valid_i & ~flush_i;

    // ------------------------------------------------------------------
    // unit valids, one cycle after acceptance
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            mult_valid_o   <= 1'b0;
            lsu_valid_o    <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= issue && (fu_i == ALU);
            branch_valid_o <= issue && (fu_i == CTRL_FLOW);
            mult_valid_o   <= issue && (fu_i == MULT);
            lsu_valid_o    <= issue && ((fu_i == LOAD) || (fu_i == STORE));
            csr_valid_o    <= issue && (fu_i == CSR);
        end
    end

    // only one unit starts per cycle
    valid_onehot_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o})
    ) else $error("more than one unit valid at once");

endmodule

`default_nettype wire

/* logic/issue_read_operands.sv */
// ----------------------------------------------------------------------
// issue and operand-read stage
// connects register file, hazard check, operand register and issue
// control of a single-issue in-order integer core
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module issue_read_operands import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  wire logic                            clk_i,
    input  wire logic                            rst_ni,
    input  wire logic                            flush_i,
    // instruction from rename
    input  wire logic                            instr_valid_i,
    input  wire fu_t                             fu_i,
    input  wire fu_op_t                          op_i,
    input  wire reg_addr_t                       rs1_i,
    input  wire reg_addr_t                       rs2_i,
    input  wire reg_addr_t                       rd_i,
    input  wire xlen_t                           imm_i,
    input  wire xlen_t                           pc_i,
    input  wire trans_id_t                       trans_id_i,
    input  wire logic                            use_imm_i,
    input  wire logic                            use_pc_i,
    input  wire logic                            use_zimm_i,
    input  wire logic                            ex_valid_i,
    output      logic                            issue_ack_o,
    // scoreboard lookup
    output      reg_addr_t                       sb_rs1_o,
    output      reg_addr_t                       sb_rs2_o,
    input  wire fu_t       [NR_REGS-1:0]         rd_clobber_i,
    input  wire xlen_t                           fwd_rs1_data_i,
    input  wire xlen_t                           fwd_rs2_data_i,
    input  wire logic                            fwd_rs1_valid_i,
    input  wire logic                            fwd_rs2_valid_i,
    // commit ports
    input  wire reg_addr_t [NR_COMMIT_PORTS-1:0] waddr_i,
    input  wire xlen_t     [NR_COMMIT_PORTS-1:0] wdata_i,
    input  wire logic      [NR_COMMIT_PORTS-1:0] we_i,
    // execute side
    input  wire logic                            flu_ready_i,
    input  wire logic                            lsu_ready_i,
    output      xlen_t                           operand_a_o,
    output      xlen_t                           operand_b_o,
    output      xlen_t                           imm_o,
    output      fu_t                             fu_o,
    output      fu_op_t                          op_o,
    output      trans_id_t                       trans_id_o,
    output      logic                            alu_valid_o,
    output      logic                            branch_valid_o,
    output      logic                            mult_valid_o,
    output      logic                            lsu_valid_o,
    output      logic                            csr_valid_o
);

    xlen_t rdata_a;
    xlen_t rdata_b;
    logic  forward_rs1;
    logic  forward_rs2;
    logic  stall;

    // scoreboard is polled with the source indices as they arrive
    assign sb_rs1_o = rs1_i;
    assign sb_rs2_o = rs2_i;

    int_regfile #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) u_int_regfile (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .raddr_a_i(rs1_i),
        .raddr_b_i(rs2_i),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b),
        .waddr_i  (waddr_i),
        .wdata_i  (wdata_i),
        .we_i     (we_i)
    );

    operand_hazard u_operand_hazard (
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .use_zimm_i     (use_zimm_i),
        .rd_clobber_i   (rd_clobber_i),
        .fwd_rs1_valid_i(fwd_rs1_valid_i),
        .fwd_rs2_valid_i(fwd_rs2_valid_i),
        .forward_rs1_o  (forward_rs1),
        .forward_rs2_o  (forward_rs2),
        .stall_o        (stall)
    );

    id_ex_operands u_id_ex_operands (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .regfile_a_i   (rdata_a),
        .regfile_b_i   (rdata_b),
        .fwd_rs1_data_i(fwd_rs1_data_i),
        .fwd_rs2_data_i(fwd_rs2_data_i),
        .forward_rs1_i (forward_rs1),
        .forward_rs2_i (forward_rs2),
        .rs1_i         (rs1_i),
        .pc_i          (pc_i),
        .imm_i         (imm_i),
        .use_pc_i      (use_pc_i),
        .use_zimm_i    (use_zimm_i),
        .use_imm_i     (use_imm_i),
        .fu_i          (fu_i),
        .op_i          (op_i),
        .trans_id_i    (trans_id_i),
        .operand_a_o   (operand_a_o),
        .operand_b_o   (operand_b_o),
        .imm_o         (imm_o),
        .fu_o          (fu_o),
        .op_o          (op_o),
        .trans_id_o    (trans_id_o)
    );

    issue_control #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) u_issue_control (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .fu_i          (fu_i),
        .rd_i          (rd_i),
        .ex_valid_i    (ex_valid_i),
        .stall_i       (stall),
        .rd_clobber_i  (rd_clobber_i),
        .waddr_i       (waddr_i),
        .we_i          (we_i),
        .flu_ready_i   (flu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .issue_ack_o   (issue_ack_o),
        .alu_valid_o   (alu_valid_o),
        .branch_valid_o(branch_valid_o),
        .mult_valid_o  (mult_valid_o),
        .lsu_valid_o   (lsu_valid_o),
        .csr_valid_o   (csr_valid_o)
    );

endmodule

`default_nettype wire

/* bench/tb_checks.svh */
// ----------------------------------------------------------------------
// testbench checks
// compare tasks for data words, single bits, unit codes, register
// indices, opcodes and tags, and the error counters they update
// ----------------------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// running totals for the closing summary
int unsigned check_count  = 0;
int unsigned value_errors = 0;
int unsigned other_errors = 0;
// vector under test, shown in every error line
int unsigned vector_index = 0;

// operands and immediates
task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
    check_count++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s vector %0d: got %h, expected %h",
                 name, vector_index, got, exp);
    end
endtask

// acknowledge and unit valids
task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s vector %0d: got %h, expected %h",
                 name, vector_index, got, exp);
    end
endtask

// functional unit code in the ID/EX register
task automatic compare_unit(input string name, input fu_t got, input fu_t exp);
    check_count++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s vector %0d: got %h, expected %h",
                 name, vector_index, got, exp);
    end
endtask

// scoreboard lookup indices
task automatic compare_index(input string name, input reg_addr_t got, input reg_addr_t exp);
    check_count++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s vector %0d: got %h, expected %h",
                 name, vector_index, got, exp);
    end
endtask

// operation code carried to execute
task automatic compare_opcode(input string name, input fu_op_t got, input fu_op_t exp);
    check_count++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s vector %0d: got %h, expected %h",
                 name, vector_index, got, exp);
    end
endtask

// scoreboard tag carried to execute
task automatic compare_tag(input string name, input trans_id_t got, input trans_id_t exp);
    check_count++;
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED %s vector %0d: got %h, expected %h",
                 name, vector_index, got, exp);
    end
endtask

// anything that is not a wrong value, such as a timeout
task automatic note_failure(input string what);
    other_errors++;
    $display("ERROR near vector %0d: %s", vector_index, what);
endtask

`endif

/* bench/tb_issue_read_operands.sv */
// ----------------------------------------------------------------------
// issue stage testbench
// replays vectors from the input file against the issue and
// operand-read stage and checks acknowledge, valids and operands
// ----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_issue_read_operands import issue_pkg::*; ();

    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned RESET_CYCLES    = 5;
    // cycles allowed for the unit valids to drop
    localparam int unsigned IDLE_TIMEOUT    = 20;
    // bound on lines read from the vector file
    localparam int unsigned MAX_LINES       = 1000;

    // ------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------
    logic clk_i, rst_ni, flush_i, instr_valid_i, issue_ack_o;
    logic use_imm_i, use_pc_i, use_zimm_i, ex_valid_i;
    logic fwd_rs1_valid_i, fwd_rs2_valid_i, flu_ready_i, lsu_ready_i;
    logic alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o;
    fu_t       fu_i, fu_o;
    fu_op_t    op_i, op_o;
    reg_addr_t rs1_i, rs2_i, rd_i, sb_rs1_o, sb_rs2_o;
    xlen_t     imm_i, pc_i, fwd_rs1_data_i, fwd_rs2_data_i;
    xlen_t     operand_a_o, operand_b_o, imm_o;
    trans_id_t trans_id_i, trans_id_o;
    fu_t       [NR_REGS-1:0]         rd_clobber_i;
    reg_addr_t [NR_COMMIT_PORTS-1:0] waddr_i;
    xlen_t     [NR_COMMIT_PORTS-1:0] wdata_i;
    logic      [NR_COMMIT_PORTS-1:0] we_i;

    // fields of the current vector, in file column order
    logic [1:0] v_we, v_fv;
    reg_addr_t  v_wa0, v_wa1, v_rs1, v_rs2, v_rd;
    xlen_t      v_wd0, v_wd1, v_imm, v_pc, v_fd1, v_fd2, v_ea, v_eb, v_ei;
    logic       v_vld, v_ack;
    logic [2:0] v_fu, v_c1, v_c2, v_cd, v_ctl;
    fu_op_t     v_op;
    trans_id_t  v_tid;
    logic [3:0] v_mode;
    logic [4:0] v_units;

    `include "tb_checks.svh"

    always #5 clk_i = ~clk_i;

    issue_read_operands #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) DUT (.*);

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    task automatic clear_clobber();
        for (int r = 0; r < NR_REGS; r++) begin
            rd_clobber_i[r] = NONE;
        end
    endtask

    // no instruction, no commit, every unit ready
    task automatic drive_idle();
        {instr_valid_i, flush_i, ex_valid_i} = 3'b000;
        {use_imm_i, use_pc_i, use_zimm_i} = 3'b000;
        {fwd_rs1_valid_i, fwd_rs2_valid_i} = 2'b00;
        {flu_ready_i, lsu_ready_i} = 2'b11;
        fu_i = NONE;
        {op_i, rs1_i, rs2_i, rd_i, trans_id_i} = '0;
        {imm_i, pc_i, fwd_rs1_data_i, fwd_rs2_data_i} = '0;
        {waddr_i, wdata_i, we_i} = '0;
        clear_clobber();
    endtask

    task automatic drive_vector();
        we_i       = v_we;
        waddr_i[0] = v_wa0;
        wdata_i[0] = v_wd0;
        waddr_i[1] = v_wa1;
        wdata_i[1] = v_wd1;
        instr_valid_i = v_vld;
        fu_i       = fu_t'(v_fu);
        op_i       = v_op;
        rs1_i      = v_rs1;
        rs2_i      = v_rs2;
        rd_i       = v_rd;
        imm_i      = v_imm;
        pc_i       = v_pc;
        trans_id_i = v_tid;
        {use_imm_i, use_pc_i, use_zimm_i, ex_valid_i} = v_mode;
        // rd entry first, source entries win on a shared index
        clear_clobber();
        if (v_cd != 3'd0) rd_clobber_i[v_rd] = fu_t'(v_cd);
        if (v_c1 != 3'd0) rd_clobber_i[v_rs1] = fu_t'(v_c1);
        if (v_c2 != 3'd0) rd_clobber_i[v_rs2] = fu_t'(v_c2);
        {fwd_rs2_valid_i, fwd_rs1_valid_i} = v_fv;
        fwd_rs1_data_i = v_fd1;
        fwd_rs2_data_i = v_fd2;
        {flu_ready_i, lsu_ready_i, flush_i} = v_ctl;
    endtask

    // outputs of the ID/EX register after the issuing edge
    task automatic check_registered();
        compare_bit("alu_valid_o", alu_valid_o, v_units[0]);
        compare_bit("branch_valid_o", branch_valid_o, v_units[1]);
        compare_bit("mult_valid_o", mult_valid_o, v_units[2]);
        compare_bit("lsu_valid_o", lsu_valid_o, v_units[3]);
        compare_bit("csr_valid_o", csr_valid_o, v_units[4]);
        compare_word("operand_a_o", operand_a_o, v_ea);
        compare_word("operand_b_o", operand_b_o, v_eb);
        compare_word("imm_o", imm_o, v_ei);
        compare_unit("fu_o", fu_o, fu_t'(v_fu));
        // opcode and tag pass through the register unchanged
        compare_opcode("op_o", op_o, v_op);
        compare_tag("trans_id_o", trans_id_o, v_tid);
    endtask

    // drive on the falling edge, ack before the rising edge, registers after
    task automatic apply_line(input string line);
        int n;
        n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    v_we, v_wa0, v_wd0, v_wa1, v_wd1, v_vld, v_fu, v_op, v_rs1,
                    v_rs2, v_rd, v_imm, v_pc, v_tid, v_mode, v_c1, v_c2, v_cd,
                    v_fv, v_fd1, v_fd2, v_ctl, v_ack, v_units, v_ea, v_eb, v_ei);
        if (n != 27) begin
            note_failure("a vector line has the wrong number of fields");
        end else begin
            vector_index++;
            @(negedge clk_i);
            drive_vector();
            #2;
            compare_bit("issue_ack_o", issue_ack_o, v_ack);
            // scoreboard lookup follows the source fields directly
            compare_index("sb_rs1_o", sb_rs1_o, v_rs1);
            compare_index("sb_rs2_o", sb_rs2_o, v_rs2);
            @(posedge clk_i);
            #2;
            check_registered();
        end
    endtask

    task automatic run_vectors();
        int fd;
        int n;
        int unsigned lines;
        string line;
        fd = $fopen("bench/issue_input.txt", "r");
        if (fd == 0) begin
            note_failure("the vector file bench/issue_input.txt could not be opened");
        end else begin
            lines = 0;
            while (!$feof(fd) && (lines < MAX_LINES)) begin
                n = $fgets(line, fd);
                lines++;
                // blank lines and # comments carry no vector
                if ((n > 1) && (line.getc(0) != "#")) begin
                    apply_line(line);
                end
            end
            $fclose(fd);
            if (vector_index == 0) begin
                note_failure("the vector file holds no vectors");
            end
        end
    endtask

    function automatic logic units_busy();
        return alu_valid_o | branch_valid_o | mult_valid_o | lsu_valid_o | csr_valid_o;
    endfunction

    task automatic wait_units_idle(input string when);
        int unsigned cycles;
        cycles = 0;
        while (units_busy() && (cycles < IDLE_TIMEOUT)) begin
            @(posedge clk_i);
            #2;
            cycles++;
        end
        if (units_busy()) begin
            note_failure({"unit valids did not drop ", when});
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        wait_units_idle("after reset");
        if (other_errors == 0) begin
            run_vectors();
            @(negedge clk_i);
            drive_idle();
            wait_units_idle("after the last vector");
        end
        $display("vectors %0d, checks %0d, value errors %0d, other errors %0d",
                 vector_index, check_count, value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+bench
logic/issue_pkg.sv
logic/int_regfile.sv
logic/operand_hazard.sv
logic/id_ex_operands.sv
logic/issue_control.sv
logic/issue_read_operands.sv
bench/tb_issue_read_operands.sv

/* run_sim.sh */
#!/bin/sh
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_issue_read_operands
BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module "$TOP" \
    --Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

/* bench/issue_input.txt */
# we wa0 wd0 wa1 wd1 | vld fu op rs1 rs2 rd imm pc tid mode(imm,pc,zimm,ex) | clob rs1 rs2 rd
# fwdv(rs2,rs1) fd1 fd2 | ctl(flu,lsu,flush) | ack units(csr,lsu,mult,br,alu) opa opb imm
3 01 11111111 02 22222222 1 1 01 01 02 03 0 0 0 0 0 0 0 0 0 0 6 1 01 0 0 0
0 0 0 0 0 1 1 01 01 02 03 0 0 1 0 0 0 0 0 0 0 6 1 01 11111111 22222222 0
3 00 DEADBEEF 04 44444444 1 1 01 00 04 06 0 0 2 0 0 0 0 0 0 0 6 1 01 0 0 0
3 05 AAAA0000 05 BBBB1111 1 1 01 00 04 06 0 0 3 0 0 0 0 0 0 0 6 1 01 0 44444444 0
0 0 0 0 0 1 1 01 05 00 06 0 0 4 0 0 0 0 0 0 0 6 1 01 BBBB1111 0 0
0 0 0 0 0 1 1 01 01 02 07 0 0 5 0 1 4 0 3 F0F0F0F0 0F0F0F0F 6 1 01 F0F0F0F0 0F0F0F0F 0
0 0 0 0 0 1 1 01 01 02 07 0 0 5 0 1 4 0 1 F0F0F0F0 0F0F0F0F 6 0 00 F0F0F0F0 22222222 0
0 0 0 0 0 1 1 01 01 02 07 0 0 5 0 6 0 0 1 12345678 0 6 0 00 11111111 22222222 0
0 0 0 0 0 1 6 02 01 00 08 0 0 6 2 1 0 0 0 0 0 6 1 10 00000001 0 0
0 0 0 0 0 1 1 01 01 02 09 00000123 80000040 7 4 0 0 0 0 0 0 6 1 01 80000040 22222222 00000123
0 0 0 0 0 1 1 03 01 02 09 FFFFF800 0 0 8 0 0 0 0 0 0 6 1 01 11111111 FFFFF800 FFFFF800
0 0 0 0 0 1 5 04 01 02 00 00000010 0 1 8 0 0 0 0 0 0 6 1 08 11111111 22222222 00000010
0 0 0 0 0 1 2 05 04 05 00 00000020 80000100 2 C 0 0 0 0 0 0 6 1 02 80000100 BBBB1111 00000020
0 0 0 0 0 1 4 06 04 00 0A 00000008 0 3 8 0 0 0 0 0 0 6 1 08 44444444 00000008 00000008
0 0 0 0 0 1 4 06 04 00 0A 00000008 0 3 8 0 0 0 0 0 0 4 0 00 44444444 00000008 00000008
0 0 0 0 0 1 1 01 01 02 03 0 0 4 0 0 0 0 0 0 0 2 0 00 11111111 22222222 0
0 0 0 0 0 1 1 01 01 02 03 0 0 4 0 0 0 0 0 0 0 7 1 00 11111111 22222222 0
0 0 0 0 0 1 3 07 01 02 0B 0 0 5 0 0 0 0 0 0 0 6 1 04 11111111 22222222 0
0 0 0 0 0 1 1 01 01 02 0C 0 0 6 0 0 0 0 0 0 0 6 0 00 11111111 22222222 0
0 0 0 0 0 1 3 07 01 02 0B 0 0 6 0 0 0 0 0 0 0 6 1 04 11111111 22222222 0
0 0 0 0 0 1 3 07 01 02 0C 0 0 7 0 0 0 0 0 0 0 6 1 04 11111111 22222222 0
0 0 0 0 0 1 1 01 01 02 0D 0 0 0 0 0 0 0 0 0 0 6 0 00 11111111 22222222 0
0 0 0 0 0 1 1 01 01 02 0D 0 0 0 0 0 0 0 0 0 0 6 1 01 11111111 22222222 0
0 0 0 0 0 1 1 01 01 02 06 0 0 1 0 0 0 1 0 0 0 6 0 00 11111111 22222222 0
2 0 0 06 66666666 1 1 01 01 02 06 0 0 1 0 0 0 1 0 0 0 6 1 01 11111111 22222222 0
0 0 0 0 0 1 1 01 06 05 06 0 0 2 1 0 0 1 0 0 0 2 1 00 66666666 BBBB1111 0
0 0 0 0 0 1 0 00 01 02 03 0 0 3 0 6 0 0 0 0 0 0 1 00 11111111 22222222 0
0 0 0 0 0 0 0 00 00 00 00 0 0 0 0 0 0 0 0 0 0 6 0 00 0 0 0
